//--- rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// datapath sizing
`define RV_XLEN      32
`define RV_REG_COUNT 32

// base opcodes, instr[6:0]
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_CAL_I  7'b0010011 // register-immediate arithmetic
`define RV_OP_CAL_R  7'b0110011 // register-register arithmetic

`endif

//--- rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_REG_COUNT)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_t;

    typedef logic [1:0] src_a_sel_t;
    typedef logic       src_b_sel_t;
    typedef logic [1:0] result_sel_t;
    typedef logic [1:0] jump_kind_t;

    localparam src_a_sel_t  src_a_reg   = 2'd0; // rs1
    localparam src_a_sel_t  src_a_pc    = 2'd1;
    localparam src_a_sel_t  src_a_zero  = 2'd2;
    localparam src_b_sel_t  src_b_reg   = 1'b0; // rs2
    localparam src_b_sel_t  src_b_imm   = 1'b1;
    localparam result_sel_t result_alu  = 2'd0;
    localparam result_sel_t result_load = 2'd1;
    localparam result_sel_t result_pc4  = 2'd2; // link address
    localparam jump_kind_t  jump_none   = 2'd0;
    localparam jump_kind_t  jump_jal    = 2'd1;
    localparam jump_kind_t  jump_jalr   = 2'd2;

endpackage

//--- control_unit.sv
`include "rv_cfg.svh"

module control_unit (
    input  logic                [6:0] opcode,
    input  logic                [2:0] funct3,
    input  logic                [6:0] funct7,
    output logic                      reg_write,
    output rv_pkg::result_sel_t       result_sel,
    output logic                      mem_write,
    output rv_pkg::jump_kind_t        jump_kind,
    output logic                      is_branch,
    output rv_pkg::alu_op_t           alu_op,
    output rv_pkg::src_a_sel_t        src_a_sel,
    output rv_pkg::src_b_sel_t        src_b_sel
);

    // flags and operand/result selects per opcode
    always_comb begin
        reg_write  = 1'b0;
        result_sel = rv_pkg::result_alu;
        mem_write  = 1'b0;
        jump_kind  = rv_pkg::jump_none;
        is_branch  = 1'b0;
        src_a_sel  = rv_pkg::src_a_reg;
        src_b_sel  = rv_pkg::src_b_imm; // only R-type takes rs2
        case (opcode)
            `RV_OP_LUI: begin
                reg_write = 1'b1;
                src_a_sel = rv_pkg::src_a_zero; // 0 + U-imm
            end
            `RV_OP_AUIPC: begin
                reg_write = 1'b1;
                src_a_sel = rv_pkg::src_a_pc;
            end
            `RV_OP_JAL: begin
                reg_write  = 1'b1;
                result_sel = rv_pkg::result_pc4;
                jump_kind  = rv_pkg::jump_jal;
                src_a_sel  = rv_pkg::src_a_pc; // target is pc + J-imm
            end
            `RV_OP_JALR: begin
                reg_write  = 1'b1;
                result_sel = rv_pkg::result_pc4;
                jump_kind  = rv_pkg::jump_jalr; // target is rs1 + I-imm
            end
            `RV_OP_BRANCH: begin
                is_branch = 1'b1;
                src_a_sel = rv_pkg::src_a_pc; // alu builds the target, compare elsewhere
            end
            `RV_OP_LOAD: begin
                reg_write  = 1'b1;
                result_sel = rv_pkg::result_load;
            end
            `RV_OP_STORE: begin
                mem_write = 1'b1;
            end
            `RV_OP_CAL_I: begin
                reg_write = 1'b1;
            end
            `RV_OP_CAL_R: begin
                reg_write = 1'b1;
                src_b_sel = rv_pkg::src_b_reg;
            end
            default: begin
                reg_write = 1'b0; // unsupported opcode, no side effects
            end
        endcase
    end

    // funct3 picks the operation, funct7[5] splits add/sub and srl/sra
    always_comb begin
        alu_op = rv_pkg::alu_add;
        if (opcode == `RV_OP_CAL_R || opcode == `RV_OP_CAL_I) begin
            case (funct3)
                3'b000: begin
                    if (opcode == `RV_OP_CAL_R && funct7[5]) begin
                        alu_op = rv_pkg::alu_sub; // no subi
                    end
                end
                3'b001: alu_op = rv_pkg::alu_sll;
                3'b010: alu_op = rv_pkg::alu_slt;
                3'b011: alu_op = rv_pkg::alu_sltu;
                3'b100: alu_op = rv_pkg::alu_xor;
                3'b101: alu_op = funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                3'b110: alu_op = rv_pkg::alu_or;
                default: alu_op = rv_pkg::alu_and;
            endcase
        end
    end

endmodule

//--- imm_gen.sv
`include "rv_cfg.svh"

module imm_gen (
    input  rv_pkg::word_t instr,
    output rv_pkg::word_t imm
);

    logic [6:0] opcode;

    assign opcode = instr[6:0];

    // format chosen by opcode, all sign-extended from instr[31]
    always_comb begin
        case (opcode)
            `RV_OP_JALR, `RV_OP_LOAD, `RV_OP_CAL_I: begin
                imm = {{20{instr[31]}}, instr[31:20]}; // I-type
            end
            `RV_OP_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]}; // S-type
            end
            `RV_OP_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0}; // B-type, even offset
            end
            `RV_OP_LUI, `RV_OP_AUIPC: begin
                imm = {instr[31:12], 12'b0}; // U-type
            end
            `RV_OP_JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0}; // J-type
            end
            default: begin
                imm = '0; // R-type has no immediate
            end
        endcase
    end

endmodule

//--- reg_file.sv
`include "rv_cfg.svh"

module reg_file (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::reg_idx_t rs1_addr,
    input  rv_pkg::reg_idx_t rs2_addr,
    input  rv_pkg::reg_idx_t rd_addr,
    input  logic             rd_write,
    input  rv_pkg::word_t    rd_data,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);

    rv_pkg::word_t regs [`RV_REG_COUNT];

    // single write port, x0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // async reads, x0 forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- alu.sv
module alu (
    input  rv_pkg::alu_op_t op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   result
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // rv32 shift amount

    always_comb begin
        case (op)
            rv_pkg::alu_add: begin
                result = a + b;
            end
            rv_pkg::alu_sub: begin
                result = a - b;
            end
            rv_pkg::alu_sll: begin
                result = a << shamt;
            end
            rv_pkg::alu_slt: begin
                result = rv_pkg::word_t'($signed(a) < $signed(b)); // 0 or 1
            end
            rv_pkg::alu_sltu: begin
                result = rv_pkg::word_t'(a < b);
            end
            rv_pkg::alu_xor: begin
                result = a ^ b;
            end
            rv_pkg::alu_srl: begin
                result = a >> shamt;
            end
            rv_pkg::alu_sra: begin
                result = rv_pkg::word_t'($signed(a) >>> shamt); // keeps sign
            end
            rv_pkg::alu_or: begin
                result = a | b;
            end
            rv_pkg::alu_and: begin
                result = a & b;
            end
            default: begin
                result = a + b; // unused encodings
            end
        endcase
    end

endmodule

//--- branch_unit.sv
module branch_unit (
    input  rv_pkg::word_t      pc,
    input  rv_pkg::word_t      rs1_data,
    input  rv_pkg::word_t      rs2_data,
    input  rv_pkg::word_t      alu_result,
    input  logic         [2:0] funct3,
    input  logic               is_branch,
    input  rv_pkg::jump_kind_t jump_kind,
    output rv_pkg::word_t      next_pc
);

    logic take;

    // branch condition from funct3
    always_comb begin
        case (funct3)
            3'b000: take = (rs1_data == rs2_data); // beq
            3'b001: take = (rs1_data != rs2_data); // bne
            3'b100: take = ($signed(rs1_data) < $signed(rs2_data)); // blt
            3'b101: take = ($signed(rs1_data) >= $signed(rs2_data)); // bge
            3'b110: take = (rs1_data < rs2_data); // bltu
            3'b111: take = (rs1_data >= rs2_data); // bgeu
            default: take = 1'b0;
        endcase
    end

    // alu already holds pc+imm for branch/jal and rs1+imm for jalr
    always_comb begin
        if (jump_kind == rv_pkg::jump_jalr) begin
            next_pc = {alu_result[$bits(rv_pkg::word_t)-1:1], 1'b0};
        end else if (jump_kind == rv_pkg::jump_jal || (is_branch && take)) begin
            next_pc = alu_result;
        end else begin
            next_pc = pc + rv_pkg::word_t'(4); // fall through
        end
    end

endmodule

//--- rv_datapath.sv
module rv_datapath (
    input  logic             clk,
    input  logic             reset,
    input  logic             instr_valid,
    input  rv_pkg::word_t    instr,
    input  rv_pkg::word_t    pc,
    input  rv_pkg::word_t    load_data,
    output rv_pkg::word_t    next_pc,
    output logic             mem_write,
    output rv_pkg::word_t    mem_addr,
    output rv_pkg::word_t    mem_wdata,
    output logic             rd_write,
    output rv_pkg::reg_idx_t rd_addr,
    output rv_pkg::word_t    rd_data
);

    logic                reg_write;
    rv_pkg::result_sel_t result_sel;
    logic                mem_write_raw;
    rv_pkg::jump_kind_t  jump_kind;
    logic                is_branch;
    rv_pkg::alu_op_t     alu_op;
    rv_pkg::src_a_sel_t  src_a_sel;
    rv_pkg::src_b_sel_t  src_b_sel;
    rv_pkg::word_t       imm;
    rv_pkg::reg_idx_t    rs1_addr;
    rv_pkg::reg_idx_t    rs2_addr;
    rv_pkg::word_t       rs1_data;
    rv_pkg::word_t       rs2_data;
    rv_pkg::word_t       alu_a;
    rv_pkg::word_t       alu_b;
    rv_pkg::word_t       alu_result;

    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];

    control_unit control_unit_i (
        .opcode     (instr[6:0]),
        .funct3     (instr[14:12]),
        .funct7     (instr[31:25]),
        .reg_write  (reg_write),
        .result_sel (result_sel),
        .mem_write  (mem_write_raw),
        .jump_kind  (jump_kind),
        .is_branch  (is_branch),
        .alu_op     (alu_op),
        .src_a_sel  (src_a_sel),
        .src_b_sel  (src_b_sel)
    );

    imm_gen imm_gen_i (
        .instr (instr),
        .imm   (imm)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .rd_write (rd_write),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // operand muxes
    always_comb begin
        case (src_a_sel)
            rv_pkg::src_a_reg: alu_a = rs1_data;
            rv_pkg::src_a_pc:  alu_a = pc;
            default:           alu_a = '0; // lui
        endcase
    end

    assign alu_b = (src_b_sel == rv_pkg::src_b_reg) ? rs2_data : imm;

    alu alu_i (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    branch_unit branch_unit_i (
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .funct3     (instr[14:12]),
        .is_branch  (is_branch),
        .jump_kind  (jump_kind),
        .next_pc    (next_pc)
    );

    // write-back source
    always_comb begin
        case (result_sel)
            rv_pkg::result_load: rd_data = load_data;
            rv_pkg::result_pc4:  rd_data = pc + rv_pkg::word_t'(4); // link
            default:             rd_data = alu_result;
        endcase
    end

    assign mem_addr  = alu_result;
    assign mem_wdata = rs2_data;

    // strobes only fire for a valid instruction
    assign mem_write = mem_write_raw & instr_valid;
    assign rd_write  = reg_write & instr_valid;

endmodule

//--- tb_rv_datapath.sv
`include "rv_cfg.svh"

module tb_rv_datapath;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 5;
    localparam int num_instr    = 100; // upper bound on issued instructions
    localparam int timeout      = (reset_cycles + num_instr + 20) * clk_period;

    // slti sltiu xori ori andi slli srli srai in order
    localparam logic [2:0] i_f3 [8] = '{3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    // add sub sll slt sltu xor srl sra or and in order
    localparam logic [2:0] r_f3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5,
                                         3'd6, 3'd7};
    localparam logic [9:0] r_alt = 10'b0010000010; // funct7[5] set for sub and sra
    localparam logic [2:0] b_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    logic             clk;
    logic             reset;
    logic             instr_valid;
    rv_pkg::word_t    instr;
    rv_pkg::word_t    pc;
    rv_pkg::word_t    load_data;
    rv_pkg::word_t    next_pc;
    logic             mem_write;
    rv_pkg::word_t    mem_addr;
    rv_pkg::word_t    mem_wdata;
    logic             rd_write;
    rv_pkg::reg_idx_t rd_addr;
    rv_pkg::word_t    rd_data;

    rv_pkg::word_t shadow [`RV_REG_COUNT]; // expected register contents
    integer        seed;
    int            errors;
    int            checks;
    int            issued;
    logic          active;
    string         test_name;

    rv_datapath dut_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .load_data   (load_data),
        .next_pc     (next_pc),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .rd_write    (rd_write),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // expected outputs of one instruction against the shadow registers
    function automatic void ref_model(
        input  rv_pkg::word_t ins,
        input  rv_pkg::word_t pc_v,
        input  rv_pkg::word_t ld,
        input  logic          valid,
        output logic          e_rw,
        output rv_pkg::word_t e_rd,
        output rv_pkg::word_t e_npc,
        output logic          e_mw,
        output rv_pkg::word_t e_addr,
        output rv_pkg::word_t e_wdata
    );
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t op_b;
        rv_pkg::word_t imm_i;
        rv_pkg::word_t imm_s;
        rv_pkg::word_t imm_b;
        rv_pkg::word_t imm_u;
        rv_pkg::word_t imm_j;
        logic [2:0]    f3;
        logic          taken;
        a       = shadow[ins[19:15]];
        b       = shadow[ins[24:20]];
        f3      = ins[14:12];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u   = {ins[31:12], 12'h000};
        imm_j   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        op_b    = (ins[6:0] == `RV_OP_CAL_R) ? b : imm_i;
        taken   = 1'b0;
        e_rw    = 1'b0;
        e_rd    = '0;
        e_npc   = pc_v + 32'd4;
        e_mw    = 1'b0;
        e_addr  = '0;
        e_wdata = b;
        case (ins[6:0])
            `RV_OP_LUI: begin
                e_rw = 1'b1;
                e_rd = imm_u;
            end
            `RV_OP_AUIPC: begin
                e_rw = 1'b1;
                e_rd = pc_v + imm_u;
            end
            `RV_OP_JAL: begin
                e_rw  = 1'b1;
                e_rd  = pc_v + 32'd4;
                e_npc = pc_v + imm_j;
            end
            `RV_OP_JALR: begin
                e_rw  = 1'b1;
                e_rd  = pc_v + 32'd4;
                e_npc = (a + imm_i) & ~32'd1; // lsb dropped
            end
            `RV_OP_BRANCH: begin
                case (f3)
                    3'b000: taken = (a == b);
                    3'b001: taken = (a != b);
                    3'b100: taken = ($signed(a) < $signed(b));
                    3'b101: taken = ($signed(a) >= $signed(b));
                    3'b110: taken = (a < b);
                    3'b111: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) e_npc = pc_v + imm_b;
            end
            `RV_OP_LOAD: begin
                e_rw   = 1'b1;
                e_rd   = ld; // whole word with no extraction
                e_addr = a + imm_i;
            end
            `RV_OP_STORE: begin
                e_mw   = 1'b1;
                e_addr = a + imm_s;
            end
            `RV_OP_CAL_I, `RV_OP_CAL_R: begin
                e_rw = 1'b1;
                case (f3)
                    3'b000: e_rd = (ins[6:0] == `RV_OP_CAL_R && ins[30]) ? a - op_b : a + op_b;
                    3'b001: e_rd = a << op_b[4:0];
                    3'b010: e_rd = {31'b0, $signed(a) < $signed(op_b)};
                    3'b011: e_rd = {31'b0, a < op_b};
                    3'b100: e_rd = a ^ op_b;
                    3'b101: e_rd = ins[30] ? rv_pkg::word_t'($signed(a) >>> op_b[4:0])
                                           : a >> op_b[4:0];
                    3'b110: e_rd = a | op_b;
                    default: e_rd = a & op_b;
                endcase
            end
            default: begin
                e_rw = 1'b0;
            end
        endcase
        e_rw = e_rw & valid;
        e_mw = e_mw & valid;
    endfunction

    function automatic rv_pkg::word_t enc_i(logic [6:0] op, logic [2:0] f3,
                                            rv_pkg::reg_idx_t rd, rv_pkg::reg_idx_t rs1,
                                            logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_pkg::word_t enc_r(logic [6:0] f7, logic [2:0] f3,
                                            rv_pkg::reg_idx_t rd, rv_pkg::reg_idx_t rs1,
                                            rv_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, `RV_OP_CAL_R};
    endfunction

    function automatic rv_pkg::word_t enc_s(rv_pkg::reg_idx_t rs1, rv_pkg::reg_idx_t rs2,
                                            logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE}; // sw
    endfunction

    function automatic rv_pkg::word_t enc_b(logic [2:0] f3, rv_pkg::reg_idx_t rs1,
                                            rv_pkg::reg_idx_t rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic rv_pkg::word_t enc_u(logic [6:0] op, rv_pkg::reg_idx_t rd,
                                            logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic rv_pkg::word_t enc_j(rv_pkg::reg_idx_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic check_value(input string field, input rv_pkg::word_t exp,
                               input rv_pkg::word_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Mismatch %s %s: expected %h, actual %h", test_name, field, exp, act);
        end
    endtask

    // drives one instruction just after the edge
    task automatic issue(input string name, input rv_pkg::word_t ins, input logic valid);
        @(posedge clk);
        #1;
        test_name   = name;
        instr       = ins;
        instr_valid = valid;
        pc          = pc + 32'd4;
        load_data   = $random(seed);
        active      = 1'b1;
        issued++;
    endtask

    // compares just before the write-back edge
    initial begin
        logic          e_rw;
        logic          e_mw;
        rv_pkg::word_t e_rd;
        rv_pkg::word_t e_npc;
        rv_pkg::word_t e_addr;
        rv_pkg::word_t e_wdata;
        forever begin
            @(posedge clk);
            #(clk_period - 1);
            if (active) begin
                ref_model(instr, pc, load_data, instr_valid,
                          e_rw, e_rd, e_npc, e_mw, e_addr, e_wdata);
                check_value("rd_write", {31'b0, e_rw}, {31'b0, rd_write});
                if (e_rw) begin
                    check_value("rd_addr", {27'b0, instr[11:7]}, {27'b0, rd_addr});
                    check_value("rd_data", e_rd, rd_data);
                end
                check_value("next_pc", e_npc, next_pc);
                check_value("mem_write", {31'b0, e_mw}, {31'b0, mem_write});
                if (e_mw || instr[6:0] == `RV_OP_LOAD) begin
                    check_value("mem_addr", e_addr, mem_addr);
                end
                if (e_mw) begin
                    check_value("mem_wdata", e_wdata, mem_wdata);
                end
                if (e_rw && instr[11:7] != 5'd0) shadow[instr[11:7]] = e_rd;
            end
        end
    end

    initial begin
        #(timeout);
        $display("watchdog expired after %0d time units, run did not finish", timeout);
        $display("summary: %0d instructions, %0d checks, %0d errors", issued, checks, errors);
        $display("Test failed");
        $finish;
    end

    initial begin
        rv_pkg::word_t r;
        seed        = 81;
        errors      = 0;
        checks      = 0;
        issued      = 0;
        active      = 1'b0;
        test_name   = "reset";
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        pc          = 32'h0000_1000;
        load_data   = '0;
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            shadow[i] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int i = 1; i <= 8; i++) begin
            r = $random(seed);
            issue("addi_seed", enc_i(`RV_OP_CAL_I, 3'b000, rv_pkg::reg_idx_t'(i), 5'd0,
                  r[11:0]), 1'b1);
        end
        for (int k = 0; k < 8; k++) begin
            r = $random(seed);
            if (k >= 5) r[11:5] = (k == 7) ? 7'h20 : 7'h00; // shifts keep a clean funct7
            issue("imm_alu", enc_i(`RV_OP_CAL_I, i_f3[k], rv_pkg::reg_idx_t'(9 + k),
                  {2'b00, r[14:12]} + 5'd1, r[11:0]), 1'b1);
        end

        for (int i = 1; i <= 8; i++) begin
            r = $random(seed);
            issue("load_seed", enc_i(`RV_OP_LOAD, 3'b010, rv_pkg::reg_idx_t'(i), 5'd0,
                  r[11:0]), 1'b1);
        end
        for (int n = 0; n < 20; n++) begin
            r = $random(seed);
            issue("reg_alu", enc_r({1'b0, r_alt[n % 10], 5'b0}, r_f3[n % 10],
                  rv_pkg::reg_idx_t'(10 + n % 10), {1'b0, r[19:16]} + 5'd1,
                  {1'b0, r[23:20]} + 5'd1), 1'b1);
        end

        issue("x0_write", enc_i(`RV_OP_CAL_I, 3'b000, 5'd0, 5'd1, 12'h07b), 1'b1);
        issue("x0_read", enc_r(7'h00, 3'b000, 5'd20, 5'd0, 5'd0), 1'b1);
        issue("wb_write", enc_i(`RV_OP_CAL_I, 3'b000, 5'd21, 5'd1, 12'h005), 1'b1);
        issue("wb_read", enc_r(7'h00, 3'b000, 5'd22, 5'd21, 5'd21), 1'b1);

        for (int i = 0; i < 3; i++) begin
            r = $random(seed);
            issue("store", enc_s({2'b00, r[14:12]} + 5'd1, {2'b00, r[17:15]} + 5'd1,
                  r[11:0]), 1'b1);
        end
        for (int i = 0; i < 2; i++) begin
            r = $random(seed);
            issue("load", enc_i(`RV_OP_LOAD, 3'b010, 5'd26, {2'b00, r[14:12]} + 5'd1,
                  r[11:0]), 1'b1);
        end

        issue("branch_setup", enc_i(`RV_OP_CAL_I, 3'b000, 5'd23, 5'd0, 12'hffb), 1'b1);
        issue("branch_setup", enc_i(`RV_OP_CAL_I, 3'b000, 5'd24, 5'd0, 12'hffb), 1'b1);
        issue("branch_setup", enc_i(`RV_OP_CAL_I, 3'b000, 5'd25, 5'd0, 12'h007), 1'b1);
        for (int k = 0; k < 6; k++) begin
            // equal pair plus -5 vs 7 and 7 vs -5 cover taken and not taken
            r = $random(seed);
            issue("branch", enc_b(b_f3[k], 5'd23, 5'd24, {r[12:1], 1'b0}), 1'b1);
            issue("branch", enc_b(b_f3[k], 5'd23, 5'd25, {r[24:13], 1'b0}), 1'b1);
            issue("branch", enc_b(b_f3[k], 5'd25, 5'd23, {r[31:25], r[5:1], 1'b0}), 1'b1);
        end
        r = $random(seed);
        issue("jal", enc_j(5'd27, {r[20:1], 1'b0}), 1'b1);
        issue("jalr_odd", enc_i(`RV_OP_JALR, 3'b000, 5'd28, 5'd25, 12'h004), 1'b1);
        r = $random(seed);
        issue("jalr", enc_i(`RV_OP_JALR, 3'b000, 5'd29, 5'd1, r[11:0]), 1'b1);

        r = $random(seed);
        issue("lui", enc_u(`RV_OP_LUI, 5'd30, r[31:12]), 1'b1);
        r = $random(seed);
        issue("auipc", enc_u(`RV_OP_AUIPC, 5'd31, r[31:12]), 1'b1);
        issue("gated_addi", enc_i(`RV_OP_CAL_I, 3'b000, 5'd1, 5'd0, 12'h063), 1'b0);
        issue("gated_store", enc_s(5'd1, 5'd2, 12'h010), 1'b0);
        issue("gated_check", enc_r(7'h00, 3'b000, 5'd30, 5'd1, 5'd0), 1'b1);

        @(posedge clk);
        #1;
        active      = 1'b0;
        instr_valid = 1'b0;
        $display("summary: %0d instructions, %0d checks, %0d errors", issued, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+.
rv_pkg.sv
control_unit.sv
imm_gen.sv
reg_file.sv
alu.sv
branch_unit.sv
rv_datapath.sv
tb_rv_datapath.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_rv_datapath
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
